// File: rtl/avr_alu.sv
// AVR byte ALU producing the result and the Z, C, N and V flags.
`timescale 1ns/1ps
`default_nettype none

module avr_alu import avr_pkg::*; (
	input wire alu_op_t alu_op,
	input wire logic [7:0] a,
	input wire logic [7:0] b,
	input wire logic imm_sel,
	input wire logic [7:0] imm,
	output logic [7:0] result,
	output logic z,
	output logic c,
	output logic n,
	output logic v
);

	logic [7:0] op_b;
	logic [8:0] sum;
	logic [8:0] diff;

	// Second operand is the immediate for LDI.
	assign op_b = imm_sel ? imm : b;

	// Nine-bit forms keep the carry and the borrow.
	assign sum = {1'b0, a} + {1'b0, op_b};
	assign diff = {1'b0, a} - {1'b0, op_b};

	always_comb begin
		result = op_b;
		c = 1'b0;
		v = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result = sum[7:0];
				c = sum[8];
				// Same operand signs, different result sign.
				v = (a[7] & op_b[7] & ~sum[7]) | (~a[7] & ~op_b[7] & sum[7]);
			end
			ALU_SUB: begin
				result = diff[7:0];
				// Borrow out of bit 7.
				c = diff[8];
				v = (a[7] & ~op_b[7] & ~diff[7]) | (~a[7] & op_b[7] & diff[7]);
			end
			ALU_AND: result = a & op_b;
			ALU_OR: result = a | op_b;
			ALU_EOR: result = a ^ op_b;
			default: result = op_b;
		endcase
	end

	// Z and N follow the result for every function.
	assign z = (result == 8'h00);
	assign n = result[7];

endmodule

`default_nettype wire

// File: rtl/avr_cfg.svh
// AVR core configuration with memory and I/O address widths and the register count.
`ifndef AVR_CFG_SVH
`define AVR_CFG_SVH

// Program memory word address width.
`define AVR_PMEM_WIDTH 12

// Data memory byte address width.
`define AVR_DMEM_WIDTH 10

// I/O space address width, 64 ports.
`define AVR_IO_WIDTH 6

// General purpose byte registers r0 to r31.
`define AVR_REG_COUNT 32

`endif

// File: rtl/avr_control.sv
// AVR sequencer holding PC, instruction register, flags and all memory and I/O strobes.
`timescale 1ns/1ps
`default_nettype none

`include "avr_cfg.svh"

module avr_control import avr_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst,
	input wire op_t op,
	input wire logic signed [11:0] offset,
	input wire logic writes_flags,
	input wire logic alu_z,
	input wire logic alu_c,
	input wire logic alu_n,
	input wire logic alu_v,
	input wire logic [7:0] alu_result,
	input wire logic [15:0] x_ptr,
	input wire logic [7:0] rr_data,
	input wire logic [7:0] dmem_di,
	input wire logic [7:0] io_di,
	input wire logic [`AVR_IO_WIDTH-1:0] io_addr,
	input wire logic [15:0] pmem_d,
	output logic pmem_ce,
	output logic [`AVR_PMEM_WIDTH-1:0] pmem_a,
	output logic [15:0] insn,
	output logic rf_we,
	output logic [7:0] rf_wdata,
	output logic dmem_we,
	output logic [`AVR_DMEM_WIDTH-1:0] dmem_a,
	output logic [7:0] dmem_do,
	output logic io_re,
	output logic io_we,
	output logic [`AVR_IO_WIDTH-1:0] io_a,
	output logic [7:0] io_do
);

	state_t state;
	state_t state_next;
	logic [`AVR_PMEM_WIDTH-1:0] pc;
	logic [`AVR_PMEM_WIDTH-1:0] pc_inc;
	logic [`AVR_PMEM_WIDTH-1:0] pc_next;
	logic [15:0] ir;
	// Status flags, bit 0 is Z, then C, N, V.
	logic [3:0] sreg;
	logic take_branch;

	// Program memory answers in EXEC, LOAD uses the stored copy.
	assign insn = (state == EXEC) ? pmem_d : ir;

	always_ff @(posedge sys_clk) begin
		if (state == EXEC)
			ir <= pmem_d;
	end

	// Fetch reads the word at PC.
	assign pmem_ce = (state == FETCH);
	assign pmem_a = pc;

	// Branch decision from the stored Z flag.
	always_comb begin
		case (op)
			OP_RJMP: take_branch = 1'b1;
			OP_BREQ: take_branch = sreg[0];
			OP_BRNE: take_branch = ~sreg[0];
			default: take_branch = 1'b0;
		endcase
	end

	// Targets are relative to the next word.
	assign pc_inc = pc + 1'b1;
	assign pc_next = take_branch ? pc_inc + `AVR_PMEM_WIDTH'(offset) : pc_inc;

	always_comb begin
		case (state)
			FETCH: state_next = EXEC;
			// Loads wait one cycle for the read data.
			EXEC: state_next = (op == OP_LD || op == OP_IN) ? LOAD : FETCH;
			default: state_next = FETCH;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst) begin
			state <= FETCH;
			pc <= '0;
			sreg <= '0;
		end else begin
			state <= state_next;
			if (state == EXEC) begin
				pc <= pc_next;
				if (writes_flags)
					sreg <= {alu_v, alu_n, alu_c, alu_z};
			end
		end
	end

	// Register writes happen in EXEC for ALU work and in LOAD for reads.
	always_comb begin
		rf_we = 1'b0;
		if (state == LOAD) begin
			rf_we = 1'b1;
		end else if (state == EXEC) begin
			case (op)
				OP_LDI, OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_EOR: rf_we = 1'b1;
				default: rf_we = 1'b0;
			endcase
		end
	end

	// Load data arrives one cycle after the request.
	assign rf_wdata = (state != LOAD) ? alu_result : (op == OP_IN) ? io_di : dmem_di;

	// Data memory is addressed by X, the stored byte is Rr.
	assign dmem_a = x_ptr[`AVR_DMEM_WIDTH-1:0];
	assign dmem_do = rr_data;
	assign dmem_we = (state == EXEC) && (op == OP_ST);

	// Single-cycle I/O strobes.
	assign io_a = io_addr;
	assign io_do = rr_data;
	assign io_we = (state == EXEC) && (op == OP_OUT);
	assign io_re = (state == EXEC) && (op == OP_IN);

endmodule

`default_nettype wire

// File: rtl/avr_decode.sv
// AVR instruction decoder splitting a 16-bit word into operation, operands and offsets.
`timescale 1ns/1ps
`default_nettype none

`include "avr_cfg.svh"

module avr_decode import avr_pkg::*; (
	input wire logic [15:0] insn,
	output op_t op,
	output alu_op_t alu_op,
	output logic [4:0] rd,
	output logic [4:0] rr,
	output logic imm_sel,
	output logic [7:0] imm,
	output logic [`AVR_IO_WIDTH-1:0] io_addr,
	output logic signed [11:0] offset,
	output logic writes_flags
);

	// LDI constant is split around the register field.
	assign imm = {insn[11:8], insn[3:0]};

	// IN and OUT port number.
	assign io_addr = {insn[10:9], insn[3:0]};

	always_comb begin
		op = OP_ILLEGAL;
		alu_op = ALU_PASS;
		imm_sel = 1'b0;
		writes_flags = 1'b0;
		// Two-operand format by default.
		rd = insn[8:4];
		rr = {insn[9], insn[3:0]};
		// Conditional branch offset, 7 bits sign extended.
		offset = {{5{insn[9]}}, insn[9:3]};

		casez (insn)
			16'b0000_0000_0000_0000: begin
				op = OP_NOP;
			end
			16'b0000_11??_????_????: begin
				op = OP_ADD;
				alu_op = ALU_ADD;
				writes_flags = 1'b1;
			end
			16'b0001_10??_????_????: begin
				op = OP_SUB;
				alu_op = ALU_SUB;
				writes_flags = 1'b1;
			end
			16'b0010_00??_????_????: begin
				op = OP_AND;
				alu_op = ALU_AND;
				writes_flags = 1'b1;
			end
			16'b0010_01??_????_????: begin
				op = OP_EOR;
				alu_op = ALU_EOR;
				writes_flags = 1'b1;
			end
			16'b0010_10??_????_????: begin
				op = OP_OR;
				alu_op = ALU_OR;
				writes_flags = 1'b1;
			end
			16'b0010_11??_????_????: begin
				op = OP_MOV;
			end
			16'b1110_????_????_????: begin
				// Only r16 to r31 are reachable.
				op = OP_LDI;
				imm_sel = 1'b1;
				rd = {1'b1, insn[7:4]};
			end
			16'b1011_0???_????_????: begin
				op = OP_IN;
			end
			16'b1011_1???_????_????: begin
				// Source register sits in the Rd field.
				op = OP_OUT;
				rr = insn[8:4];
			end
			16'b1001_000?_????_1100: begin
				op = OP_LD;
			end
			16'b1001_001?_????_1100: begin
				op = OP_ST;
				rr = insn[8:4];
			end
			16'b1100_????_????_????: begin
				op = OP_RJMP;
				offset = insn[11:0];
			end
			16'b1111_00??_????_?001: begin
				op = OP_BREQ;
			end
			16'b1111_01??_????_?001: begin
				op = OP_BRNE;
			end
			default: begin
				op = OP_ILLEGAL;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/avr_pkg.sv
// AVR core types for decoded operations, ALU functions and the sequencer states.
`default_nettype none

package avr_pkg;

	// One value per supported instruction.
	// Unknown words map to OP_ILLEGAL and run as a NOP.
	typedef enum logic [3:0] {
		OP_NOP,
		OP_LDI,
		OP_MOV,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_IN,
		OP_OUT,
		OP_LD,
		OP_ST,
		OP_RJMP,
		OP_BREQ,
		OP_BRNE,
		OP_ILLEGAL
	} op_t;

	// Byte ALU functions.
	// PASS forwards the second operand or the immediate.
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_PASS
	} alu_op_t;

	// Sequencer states, one instruction in flight.
	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		LOAD
	} state_t;

endpackage

`default_nettype wire

// File: rtl/avr_regfile.sv
// AVR register file with two combinational read ports, one write port and the X pointer.
`timescale 1ns/1ps
`default_nettype none

`include "avr_cfg.svh"

module avr_regfile (
	input wire logic sys_clk,
	input wire logic [4:0] rd,
	input wire logic [4:0] rr,
	input wire logic we,
	input wire logic [7:0] wdata,
	output logic [7:0] rd_data,
	output logic [7:0] rr_data,
	output logic [15:0] x_ptr
);

	// Register storage, contents undefined until written.
	logic [7:0] regs [0:`AVR_REG_COUNT-1];

	// Asynchronous reads.
	assign rd_data = regs[rd];
	assign rr_data = regs[rr];

	// X is r27:r26, high byte first.
	assign x_ptr = {regs[27], regs[26]};

	// Destination is always the Rd field.
	always_ff @(posedge sys_clk) begin
		if (we)
			regs[rd] <= wdata;
	end

endmodule

`default_nettype wire

// File: rtl/avr_top.sv
// AVR core top level joining decoder, register file, ALU and sequencer to the buses.
`timescale 1ns/1ps
`default_nettype none

`include "avr_cfg.svh"

module avr_top import avr_pkg::*; (
	input wire logic sys_clk,
	input wire logic sys_rst,
	output logic pmem_ce,
	output logic [`AVR_PMEM_WIDTH-1:0] pmem_a,
	input wire logic [15:0] pmem_d,
	output logic dmem_we,
	output logic [`AVR_DMEM_WIDTH-1:0] dmem_a,
	output logic [7:0] dmem_do,
	input wire logic [7:0] dmem_di,
	output logic io_re,
	output logic io_we,
	output logic [`AVR_IO_WIDTH-1:0] io_a,
	output logic [7:0] io_do,
	input wire logic [7:0] io_di
);

	// Decoded fields.
	logic [15:0] insn;
	op_t op;
	alu_op_t alu_op;
	logic [4:0] rd;
	logic [4:0] rr;
	logic imm_sel;
	logic [7:0] imm;
	logic [`AVR_IO_WIDTH-1:0] io_addr;
	logic signed [11:0] offset;
	logic writes_flags;

	// Datapath.
	logic [7:0] rd_data;
	logic [7:0] rr_data;
	logic [15:0] x_ptr;
	logic rf_we;
	logic [7:0] rf_wdata;
	logic [7:0] alu_result;
	logic alu_z;
	logic alu_c;
	logic alu_n;
	logic alu_v;

	avr_decode u_decode (
		.insn(insn),
		.op(op),
		.alu_op(alu_op),
		.rd(rd),
		.rr(rr),
		.imm_sel(imm_sel),
		.imm(imm),
		.io_addr(io_addr),
		.offset(offset),
		.writes_flags(writes_flags)
	);

	avr_regfile u_regfile (
		.sys_clk(sys_clk),
		.rd(rd),
		.rr(rr),
		.we(rf_we),
		.wdata(rf_wdata),
		.rd_data(rd_data),
		.rr_data(rr_data),
		.x_ptr(x_ptr)
	);

	avr_alu u_alu (
		.alu_op(alu_op),
		.a(rd_data),
		.b(rr_data),
		.imm_sel(imm_sel),
		.imm(imm),
		.result(alu_result),
		.z(alu_z),
		.c(alu_c),
		.n(alu_n),
		.v(alu_v)
	);

	avr_control u_control (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.op(op),
		.offset(offset),
		.writes_flags(writes_flags),
		.alu_z(alu_z),
		.alu_c(alu_c),
		.alu_n(alu_n),
		.alu_v(alu_v),
		.alu_result(alu_result),
		.x_ptr(x_ptr),
		.rr_data(rr_data),
		.dmem_di(dmem_di),
		.io_di(io_di),
		.io_addr(io_addr),
		.pmem_d(pmem_d),
		.pmem_ce(pmem_ce),
		.pmem_a(pmem_a),
		.insn(insn),
		.rf_we(rf_we),
		.rf_wdata(rf_wdata),
		.dmem_we(dmem_we),
		.dmem_a(dmem_a),
		.dmem_do(dmem_do),
		.io_re(io_re),
		.io_we(io_we),
		.io_a(io_a),
		.io_do(io_do)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the AVR core testbench with Verilator.

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module avr_tb -Mdir obj_dir -o avr_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/avr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
	echo "RESULT: PASS"
	exit 0
else
	echo "RESULT: FAIL"
	exit 1
fi

// File: tb/avr_iss.svh
// Instruction-set model, random program generator and LCG for the AVR core testbench.
`ifndef AVR_ISS_SVH
`define AVR_ISS_SVH

localparam int PROG_LEN = 256;
localparam int END_PC = PROG_LEN - 1;
localparam int DMEM_SIZE = 1 << `AVR_DMEM_WIDTH;

// I/O read data is the port number plus this constant.
localparam logic [7:0] IO_BASE = 8'h5A;

// Instruction kinds known to the model.
typedef enum int {
	K_NOP,
	K_LDI,
	K_MOV,
	K_ADD,
	K_SUB,
	K_AND,
	K_OR,
	K_EOR,
	K_IN,
	K_OUT,
	K_LD,
	K_ST,
	K_RJMP,
	K_BREQ,
	K_BRNE
} kind_t;

int unsigned rng_state = 50219;

// Program as fields for the model and as words for the DUT.
kind_t p_kind [0:PROG_LEN-1];
int p_d [0:PROG_LEN-1];
int p_r [0:PROG_LEN-1];
int p_k [0:PROG_LEN-1];
logic [15:0] p_word [0:PROG_LEN-1];

// Model state.
logic [7:0] m_regs [0:31];
logic [7:0] m_dmem [0:DMEM_SIZE-1];
logic m_z;
int exec_count;

// Expected writes in program order, address above data.
logic [`AVR_DMEM_WIDTH+7:0] dmem_q [$];
logic [`AVR_IO_WIDTH+7:0] io_q [$];

// LCG step, upper bits are the better ones.
function automatic int rand_below(input int n);
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return int'((rng_state >> 16) % 32'(n));
endfunction

// Stores one instruction and its encoding.
task automatic put_insn(input int pc, input kind_t kind, input int d, input int r, input int k);
	logic [15:0] w;
	case (kind)
		K_LDI: w = 16'hE000 | 16'(((k & 240) << 4) | ((d - 16) << 4) | (k & 15));
		K_MOV: w = 16'h2C00 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_ADD: w = 16'h0C00 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_SUB: w = 16'h1800 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_AND: w = 16'h2000 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_EOR: w = 16'h2400 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_OR: w = 16'h2800 | 16'(((r & 16) << 5) | (d << 4) | (r & 15));
		K_IN: w = 16'hB000 | 16'(((k & 48) << 5) | (d << 4) | (k & 15));
		K_OUT: w = 16'hB800 | 16'(((k & 48) << 5) | (r << 4) | (k & 15));
		K_LD: w = 16'h900C | 16'(d << 4);
		K_ST: w = 16'h920C | 16'(r << 4);
		K_RJMP: w = 16'hC000 | 16'(k & 4095);
		K_BREQ: w = 16'hF001 | 16'((k & 127) << 3);
		K_BRNE: w = 16'hF401 | 16'((k & 127) << 3);
		default: w = 16'h0000;
	endcase
	p_kind[pc] = kind;
	p_d[pc] = d;
	p_r[pc] = r;
	p_k[pc] = k;
	p_word[pc] = w;
endtask

task automatic build_program();
	int sel;
	int d;
	int r;
	int port;
	int off;
	// Load r16 to r31, X in r27:r26 stays inside data memory.
	for (int i = 0; i < 16; i++)
		put_insn(i, K_LDI, 16 + i, 0, (i == 11) ? rand_below(4) : rand_below(256));
	// Copy into r0 to r15 so every register holds a known value.
	for (int i = 0; i < 16; i++)
		put_insn(16 + i, K_MOV, i, 16 + i, 0);
	for (int pc = 32; pc < END_PC; pc++) begin
		sel = rand_below(16);
		d = rand_below(32);
		r = rand_below(32);
		port = rand_below(64);
		off = rand_below(8);
		// Forward only, never past the final jump.
		if (off > END_PC - 1 - pc)
			off = END_PC - 1 - pc;
		case (sel)
			0: put_insn(pc, K_ADD, d, r, 0);
			1: put_insn(pc, K_SUB, d, r, 0);
			2: put_insn(pc, K_AND, d, r, 0);
			3: put_insn(pc, K_OR, d, r, 0);
			4: put_insn(pc, K_EOR, d, r, 0);
			5: put_insn(pc, K_MOV, d, r, 0);
			6: put_insn(pc, K_IN, d, 0, port);
			7, 8: put_insn(pc, K_OUT, 0, r, port);
			9: put_insn(pc, K_LD, d, 0, 0);
			10, 11: put_insn(pc, K_ST, 0, r, 0);
			12: put_insn(pc, K_BREQ, 0, 0, off);
			13: put_insn(pc, K_BRNE, 0, 0, off);
			14: put_insn(pc, K_LDI, d | 16, 0, rand_below(256));
			default: put_insn(pc, K_RJMP, 0, 0, off);
		endcase
	end
	// Jump to itself marks the end.
	put_insn(END_PC, K_RJMP, 0, 0, -1);
endtask

task automatic fill_data_model();
	for (int i = 0; i < DMEM_SIZE; i++)
		m_dmem[i] = 8'(rand_below(256));
endtask

// ALU result goes to Rd and sets Z.
task automatic alu_write(input int d, input logic [7:0] res);
	m_regs[d] = res;
	m_z = (res == 8'h00);
endtask

task automatic run_model();
	int pc;
	int xa;
	logic [7:0] a;
	logic [7:0] b;
	logic taken;
	pc = 0;
	m_z = 1'b0;
	exec_count = 0;
	while (pc != END_PC && exec_count < 4 * PROG_LEN) begin
		a = m_regs[p_d[pc]];
		b = m_regs[p_r[pc]];
		// Data address wraps to the memory size.
		xa = int'({m_regs[27], m_regs[26]}) % DMEM_SIZE;
		exec_count++;
		case (p_kind[pc])
			K_LDI: m_regs[p_d[pc]] = 8'(p_k[pc]);
			K_MOV: m_regs[p_d[pc]] = b;
			K_ADD: alu_write(p_d[pc], a + b);
			K_SUB: alu_write(p_d[pc], a - b);
			K_AND: alu_write(p_d[pc], a & b);
			K_OR: alu_write(p_d[pc], a | b);
			K_EOR: alu_write(p_d[pc], a ^ b);
			K_IN: m_regs[p_d[pc]] = 8'(p_k[pc]) + IO_BASE;
			K_OUT: io_q.push_back({`AVR_IO_WIDTH'(p_k[pc]), b});
			K_LD: m_regs[p_d[pc]] = m_dmem[xa];
			K_ST: begin
				m_dmem[xa] = b;
				dmem_q.push_back({`AVR_DMEM_WIDTH'(xa), b});
			end
			default: ;
		endcase
		taken = (p_kind[pc] == K_RJMP) || (p_kind[pc] == K_BREQ && m_z) ||
			(p_kind[pc] == K_BRNE && !m_z);
		pc = taken ? pc + 1 + p_k[pc] : pc + 1;
	end
endtask

`endif

// File: tb/avr_tb.sv
// Testbench running a random program on the AVR core against an instruction-set model.
`timescale 1ns/1ps
`default_nettype none

`include "avr_cfg.svh"

module avr_tb;

	logic sys_clk;
	logic sys_rst;
	logic pmem_ce;
	logic [`AVR_PMEM_WIDTH-1:0] pmem_a;
	logic [15:0] pmem_d;
	logic dmem_we;
	logic [`AVR_DMEM_WIDTH-1:0] dmem_a;
	logic [7:0] dmem_do;
	logic [7:0] dmem_di;
	logic io_re;
	logic io_we;
	logic [`AVR_IO_WIDTH-1:0] io_a;
	logic [7:0] io_do;
	logic [7:0] io_di;

	// Bench memories.
	logic [15:0] pmem [0:(1 << `AVR_PMEM_WIDTH)-1];
	logic [7:0] dmem [0:(1 << `AVR_DMEM_WIDTH)-1];

	int cycle;
	int limit;
	logic fetch_seen;

	`include "avr_iss.svh"

	avr_top dut_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pmem_ce(pmem_ce),
		.pmem_a(pmem_a),
		.pmem_d(pmem_d),
		.dmem_we(dmem_we),
		.dmem_a(dmem_a),
		.dmem_do(dmem_do),
		.dmem_di(dmem_di),
		.io_re(io_re),
		.io_we(io_we),
		.io_a(io_a),
		.io_do(io_do),
		.io_di(io_di)
	);

	always #4 sys_clk = ~sys_clk;

	task automatic report_error(input string text);
		$display("%s", text);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst <= 1'b0;
		pmem_d <= 16'h0000;
		dmem_di <= 8'h00;
		io_di <= 8'h00;
		cycle = 0;
		fetch_seen = 1'b0;
		build_program();
		fill_data_model();
		// Words past the program read as NOP.
		for (int i = 0; i < (1 << `AVR_PMEM_WIDTH); i++)
			pmem[i] = (i < PROG_LEN) ? p_word[i] : 16'h0000;
		for (int i = 0; i < DMEM_SIZE; i++)
			dmem[i] <= m_dmem[i];
		run_model();
		// Three cycles at most per instruction plus reset and some slack.
		limit = 3 * exec_count + 16 + 32;
		repeat (16) @(posedge sys_clk);
		sys_rst <= 1'b1;
	end

	// Program memory with a registered read.
	always @(posedge sys_clk) begin
		if (pmem_ce)
			pmem_d <= pmem[pmem_a];
	end

	// Data memory with one cycle of read latency.
	always @(posedge sys_clk) begin
		if (dmem_we)
			dmem[dmem_a] <= dmem_do;
		dmem_di <= dmem[dmem_a];
	end

	// I/O read data follows the port number.
	always @(posedge sys_clk) begin
		if (io_re)
			io_di <= {2'b00, io_a} + IO_BASE;
	end

	always @(posedge sys_clk) begin
		cycle = cycle + 1;
		if (cycle >= limit)
			report_error($sformatf("timeout after %0d cycles, program end not reached", cycle));
	end

	task automatic check_dmem_write();
		logic [`AVR_DMEM_WIDTH-1:0] exp_a;
		logic [7:0] exp_d;
		assert (fetch_seen) else
			report_error("data memory write before the first instruction fetch");
		assert (dmem_q.size() != 0) else
			report_error("data memory write that the model does not expect");
		{exp_a, exp_d} = dmem_q.pop_front();
		assert (dmem_a == exp_a) else
			report_error($sformatf("[FAIL] dmem_a: got %h expected %h", dmem_a, exp_a));
		assert (dmem_do == exp_d) else
			report_error($sformatf("[FAIL] dmem_do: got %h expected %h", dmem_do, exp_d));
	endtask

	task automatic check_io_write();
		logic [`AVR_IO_WIDTH-1:0] exp_a;
		logic [7:0] exp_d;
		assert (fetch_seen) else
			report_error("I/O write before the first instruction fetch");
		assert (io_q.size() != 0) else
			report_error("I/O write that the model does not expect");
		{exp_a, exp_d} = io_q.pop_front();
		assert (io_a == exp_a) else
			report_error($sformatf("[FAIL] io_a: got %h expected %h", io_a, exp_a));
		assert (io_do == exp_d) else
			report_error($sformatf("[FAIL] io_do: got %h expected %h", io_do, exp_d));
	endtask

	// The final self-jump is fetched and every expected write must be done.
	task automatic finish_run();
		if (dmem_q.size() == 0 && io_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			report_error($sformatf("program ended with %0d data and %0d I/O writes missing",
				dmem_q.size(), io_q.size()));
		end
	endtask

	// Outputs are settled at the falling edge.
	always @(negedge sys_clk) begin
		if (!sys_rst) begin
			// State is known after the first edge in reset.
			if (cycle > 0) begin
				assert (!dmem_we && !io_we && !io_re) else
					report_error("write or read strobe active during reset");
			end
		end else begin
			if (dmem_we)
				check_dmem_write();
			if (io_we)
				check_io_write();
			if (pmem_ce && !fetch_seen) begin
				assert (pmem_a == '0) else
					report_error($sformatf("[FAIL] pmem_a: got %h expected %h", pmem_a, 12'h000));
				fetch_seen = 1'b1;
			end
			if (pmem_ce && pmem_a == `AVR_PMEM_WIDTH'(END_PC))
				finish_run();
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
+incdir+tb
rtl/avr_pkg.sv
rtl/avr_decode.sv
rtl/avr_regfile.sv
rtl/avr_alu.sv
rtl/avr_control.sv
rtl/avr_top.sv
tb/avr_tb.sv
